/* lc4_pkg.sv */
package lc4_pkg;

   typedef logic [15:0] word_t;     // data, address or instruction
   typedef logic [2:0]  reg_sel_t;  // register number
   typedef logic [2:0]  nzp_t;      // {n, z, p}
   typedef logic [3:0]  opcode_t;   // insn[15:12]

   localparam word_t RESET_PC = 16'h8200;
   localparam word_t NOP_INSN = 16'h0000;  // BR with empty mask

   localparam opcode_t OP_BR    = 4'b0000;
   localparam opcode_t OP_ADD   = 4'b0001;
   localparam opcode_t OP_AND   = 4'b0101;
   localparam opcode_t OP_LDR   = 4'b0110;
   localparam opcode_t OP_STR   = 4'b0111;
   localparam opcode_t OP_CONST = 4'b1001;

   // why a slot carries no instruction, same codes as the trace port
   typedef enum logic [1:0] {
      BUBBLE_NONE     = 2'd0,
      BUBBLE_MISPRED  = 2'd2,
      BUBBLE_LOAD_USE = 2'd3
   } bubble_t;

   typedef struct packed {
      reg_sel_t rs;
      reg_sel_t rt;
      reg_sel_t rd;
      logic     rs_re;
      logic     rt_re;
      logic     rd_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
   } decode_t;

   // contents of one pipeline register
   typedef struct packed {
      word_t   pc;
      word_t   insn;
      bubble_t bubble;
      decode_t dec;
      word_t   rs_data;
      word_t   rt_data;  // store data once past execute
      word_t   result;   // alu result, or writeback value in W
   } stage_t;

   typedef struct packed {
      word_t    pc;
      word_t    insn;
      bubble_t  bubble;
      logic     rf_we;
      reg_sel_t rd;
      word_t    rf_data;
      logic     nzp_we;
      nzp_t     nzp;
   } wb_trace_t;

endpackage

/* lc4_decoder.sv */
`timescale 1ns/1ps

module lc4_decoder (
   input  lc4_pkg::word_t   i_insn,
   output lc4_pkg::decode_t o_dec
);

   lc4_pkg::opcode_t opcode;

   assign opcode = i_insn[15:12];

   always_comb begin
      o_dec = '0;  // anything not listed below stays a NOP
      case (opcode)
         lc4_pkg::OP_BR: begin
            o_dec.is_branch = (i_insn[11:9] != 3'b000);  // empty mask is a NOP
         end
         lc4_pkg::OP_ADD: begin
            // register form needs sub-op 000, immediate form has bit 5 set
            if (i_insn[5] || (i_insn[5:3] == 3'b000)) begin
               o_dec.rd     = i_insn[11:9];
               o_dec.rs     = i_insn[8:6];
               o_dec.rt     = i_insn[2:0];
               o_dec.rs_re  = 1'b1;
               o_dec.rt_re  = ~i_insn[5];
               o_dec.rd_we  = 1'b1;
               o_dec.nzp_we = 1'b1;
            end
         end
         lc4_pkg::OP_AND: begin
            if (i_insn[5:3] == 3'b000) begin  // register AND only
               o_dec.rd     = i_insn[11:9];
               o_dec.rs     = i_insn[8:6];
               o_dec.rt     = i_insn[2:0];
               o_dec.rs_re  = 1'b1;
               o_dec.rt_re  = 1'b1;
               o_dec.rd_we  = 1'b1;
               o_dec.nzp_we = 1'b1;
            end
         end
         lc4_pkg::OP_LDR: begin
            o_dec.rd      = i_insn[11:9];
            o_dec.rs      = i_insn[8:6];
            o_dec.rs_re   = 1'b1;
            o_dec.rd_we   = 1'b1;
            o_dec.nzp_we  = 1'b1;
            o_dec.is_load = 1'b1;
         end
         lc4_pkg::OP_STR: begin
            o_dec.rt       = i_insn[11:9];  // data register
            o_dec.rs       = i_insn[8:6];   // base register
            o_dec.rs_re    = 1'b1;
            o_dec.rt_re    = 1'b1;
            o_dec.is_store = 1'b1;
         end
         lc4_pkg::OP_CONST: begin
            o_dec.rd     = i_insn[11:9];
            o_dec.rd_we  = 1'b1;
            o_dec.nzp_we = 1'b1;
         end
         default: begin
            o_dec = '0;
         end
      endcase
   end

endmodule

/* lc4_alu.sv */
`timescale 1ns/1ps

module lc4_alu (
   input  lc4_pkg::word_t i_insn,
   input  lc4_pkg::word_t i_rs_data,
   input  lc4_pkg::word_t i_rt_data,
   output lc4_pkg::word_t o_result
);

   lc4_pkg::word_t imm5;
   lc4_pkg::word_t imm6;
   lc4_pkg::word_t imm9;

   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      case (i_insn[15:12])
         lc4_pkg::OP_ADD: begin
            o_result = i_insn[5] ? (i_rs_data + imm5) : (i_rs_data + i_rt_data);
         end
         lc4_pkg::OP_AND: begin
            o_result = i_rs_data & i_rt_data;
         end
         lc4_pkg::OP_CONST: begin
            o_result = imm9;
         end
         lc4_pkg::OP_LDR, lc4_pkg::OP_STR: begin
            o_result = i_rs_data + imm6;  // effective address
         end
         default: begin
            o_result = '0;  // branches and NOPs
         end
      endcase
   end

endmodule

/* lc4_regfile.sv */
`timescale 1ns/1ps

module lc4_regfile (
   input  logic                gwe,
   input  logic                i_rst_n,
   input  lc4_pkg::reg_sel_t   i_rs,
   input  lc4_pkg::reg_sel_t   i_rt,
   output lc4_pkg::word_t      o_rs_data,
   output lc4_pkg::word_t      o_rt_data,
   input  lc4_pkg::reg_sel_t   i_rd,
   input  lc4_pkg::word_t      i_wdata,
   input  logic                i_we
);

   lc4_pkg::word_t regs [8];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // write-before-read: a same-cycle write is seen by decode
   assign o_rs_data = (i_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

/* lc4_hazard_unit.sv */
`timescale 1ns/1ps

module lc4_hazard_unit (
   input  lc4_pkg::decode_t i_dec_d,
   input  lc4_pkg::decode_t i_dec_x,
   input  lc4_pkg::nzp_t    i_br_mask_x,
   input  lc4_pkg::nzp_t    i_nzp,
   output logic             o_stall,
   output logic             o_flush
);

   logic rs_dep;
   logic rt_dep;
   logic load_use;
   logic taken;

   // decode needs the register a load in execute is about to return
   assign rs_dep = i_dec_d.rs_re && (i_dec_d.rs == i_dec_x.rd);
   assign rt_dep = i_dec_d.rt_re && (i_dec_d.rt == i_dec_x.rd)
                   && !i_dec_d.is_store;  // store data comes late via WM bypass

   // a branch behind a load waits for the load's nzp
   assign load_use = i_dec_x.is_load && i_dec_x.rd_we
                     && (rs_dep || rt_dep || i_dec_d.is_branch);

   assign taken = i_dec_x.is_branch && ((i_br_mask_x & i_nzp) != 3'b000);

   assign o_flush = taken;
   assign o_stall = load_use && !taken;  // flush wins

endmodule

/* lc4_processor.sv */
`timescale 1ns/1ps

module lc4_processor (
   input  logic               gwe,
   input  logic               i_rst_n,
   output lc4_pkg::word_t     o_imem_addr,
   input  lc4_pkg::word_t     i_imem_insn,
   output lc4_pkg::word_t     o_dmem_addr,
   input  lc4_pkg::word_t     i_dmem_rdata,
   output logic               o_dmem_we,
   output lc4_pkg::word_t     o_dmem_wdata,
   output lc4_pkg::wb_trace_t o_wb
);

   // empty slot tagged with the reason it exists
   function automatic lc4_pkg::stage_t bubble_stage(input lc4_pkg::bubble_t cause);
      lc4_pkg::stage_t s;
      s        = '0;
      s.insn   = lc4_pkg::NOP_INSN;
      s.bubble = cause;
      return s;
   endfunction

   function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t value);
      logic neg;
      logic zero;
      neg  = value[15];
      zero = (value == 16'h0000);
      return {neg, zero, !neg && !zero};
   endfunction

   // MX has priority over WX, regfile value otherwise
   function automatic lc4_pkg::word_t fwd(input lc4_pkg::reg_sel_t sel,
                                          input lc4_pkg::word_t    rf_val,
                                          input lc4_pkg::stage_t   m,
                                          input lc4_pkg::word_t    m_val,
                                          input lc4_pkg::stage_t   w);
      if (m.dec.rd_we && (m.dec.rd == sel)) begin
         return m_val;
      end else if (w.dec.rd_we && (w.dec.rd == sel)) begin
         return w.result;
      end
      return rf_val;
   endfunction

   lc4_pkg::word_t   pc_q;
   lc4_pkg::word_t   pc_next;
   lc4_pkg::word_t   br_target;
   lc4_pkg::stage_t  d_q;
   lc4_pkg::stage_t  x_q;
   lc4_pkg::stage_t  m_q;
   lc4_pkg::stage_t  w_q;
   lc4_pkg::stage_t  d_next;
   lc4_pkg::stage_t  x_next;
   lc4_pkg::stage_t  m_next;
   lc4_pkg::stage_t  w_next;
   lc4_pkg::decode_t dec_d;
   lc4_pkg::word_t   rs_rf;
   lc4_pkg::word_t   rt_rf;
   lc4_pkg::word_t   rs_byp;
   lc4_pkg::word_t   rt_byp;
   lc4_pkg::word_t   alu_res;
   lc4_pkg::word_t   st_data;
   lc4_pkg::word_t   m_wdata;
   lc4_pkg::nzp_t    nzp_q;
   lc4_pkg::nzp_t    m_nzp;
   lc4_pkg::nzp_t    nzp_eff;
   logic             stall;
   logic             flush;

   // fetch
   assign o_imem_addr = pc_q;
   assign br_target   = x_q.pc + 16'd1 + {{7{x_q.insn[8]}}, x_q.insn[8:0]};
   assign pc_next     = flush ? br_target : (stall ? pc_q : pc_q + 16'd1);

   // decode
   lc4_decoder i_lc4_decoder (
      .i_insn (d_q.insn),
      .o_dec  (dec_d)
   );

   lc4_regfile i_lc4_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (dec_d.rs),
      .i_rt      (dec_d.rt),
      .o_rs_data (rs_rf),
      .o_rt_data (rt_rf),
      .i_rd      (w_q.dec.rd),
      .i_wdata   (w_q.result),
      .i_we      (w_q.dec.rd_we)
   );

   lc4_hazard_unit i_lc4_hazard_unit (
      .i_dec_d     (dec_d),
      .i_dec_x     (x_q.dec),
      .i_br_mask_x (x_q.insn[11:9]),
      .i_nzp       (nzp_eff),
      .o_stall     (stall),
      .o_flush     (flush)
   );

   // execute
   assign rs_byp = fwd(x_q.dec.rs, x_q.rs_data, m_q, m_wdata, w_q);
   assign rt_byp = fwd(x_q.dec.rt, x_q.rt_data, m_q, m_wdata, w_q);

   lc4_alu i_lc4_alu (
      .i_insn    (x_q.insn),
      .i_rs_data (rs_byp),
      .i_rt_data (rt_byp),
      .o_result  (alu_res)
   );

   // memory
   assign st_data = (w_q.dec.rd_we && (w_q.dec.rd == m_q.dec.rt)) ? w_q.result
                                                                   : m_q.rt_data;  // WM
   assign o_dmem_addr  = (m_q.dec.is_load || m_q.dec.is_store) ? m_q.result : 16'h0000;
   assign o_dmem_we    = m_q.dec.is_store;
   assign o_dmem_wdata = m_q.dec.is_store ? st_data : 16'h0000;
   assign m_wdata      = m_q.dec.is_load ? i_dmem_rdata : m_q.result;
   assign m_nzp        = nzp_of(m_wdata);
   assign nzp_eff      = m_q.dec.nzp_we ? m_nzp : nzp_q;  // what a branch in X sees

   always_comb begin
      d_next        = '0;
      d_next.pc     = pc_q;
      d_next.insn   = i_imem_insn;
      d_next.bubble = lc4_pkg::BUBBLE_NONE;
      if (flush) begin
         d_next = bubble_stage(lc4_pkg::BUBBLE_MISPRED);
      end else if (stall) begin
         d_next = d_q;  // hold decode
      end

      x_next.pc      = d_q.pc;
      x_next.insn    = d_q.insn;
      x_next.bubble  = d_q.bubble;
      x_next.dec     = dec_d;
      x_next.rs_data = rs_rf;
      x_next.rt_data = rt_rf;
      x_next.result  = '0;
      if (flush) begin
         x_next = bubble_stage(lc4_pkg::BUBBLE_MISPRED);
      end else if (stall) begin
         x_next = bubble_stage(lc4_pkg::BUBBLE_LOAD_USE);
      end

      m_next         = x_q;
      m_next.rs_data = rs_byp;
      m_next.rt_data = rt_byp;
      m_next.result  = alu_res;

      w_next         = m_q;
      w_next.rt_data = st_data;
      w_next.result  = m_wdata;  // load data or alu result
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q  <= lc4_pkg::RESET_PC;
         d_q   <= bubble_stage(lc4_pkg::BUBBLE_MISPRED);
         x_q   <= bubble_stage(lc4_pkg::BUBBLE_MISPRED);
         m_q   <= bubble_stage(lc4_pkg::BUBBLE_MISPRED);
         w_q   <= bubble_stage(lc4_pkg::BUBBLE_MISPRED);
         nzp_q <= 3'b010;
      end else begin
         pc_q <= pc_next;
         d_q  <= d_next;
         x_q  <= x_next;
         m_q  <= m_next;
         w_q  <= w_next;
         if (m_q.dec.nzp_we) begin
            nzp_q <= m_nzp;  // commits as the insn leaves memory
         end
      end
   end

   // retire trace from writeback
   assign o_wb.pc      = w_q.pc;
   assign o_wb.insn    = w_q.insn;
   assign o_wb.bubble  = w_q.bubble;
   assign o_wb.rf_we   = w_q.dec.rd_we;
   assign o_wb.rd      = w_q.dec.rd;
   assign o_wb.rf_data = w_q.result;
   assign o_wb.nzp_we  = w_q.dec.nzp_we;
   assign o_wb.nzp     = nzp_of(w_q.result);

endmodule

/* lc4_processor_props.sv */
`timescale 1ns/1ps

module lc4_processor_props (
   input logic                gwe,
   input logic                i_rst_n,
   input lc4_pkg::wb_trace_t  i_wb,
   input logic                i_dmem_we,
   input lc4_pkg::word_t      i_dmem_addr,
   input lc4_pkg::word_t      i_pc,
   input logic                i_flush,
   input logic [1:0]          i_d_bubble,
   input logic [1:0]          i_x_bubble,
   input logic [1:0]          i_m_bubble
);

   // empty slots never change architectural state
   bubble_quiet: assert property (@(posedge gwe) disable iff (!i_rst_n)
      (i_wb.bubble != lc4_pkg::BUBBLE_NONE) |-> (!i_wb.rf_we && !i_wb.nzp_we))
      else $error("bubble in writeback updates the register file or nzp");

   bubble_no_store: assert property (@(posedge gwe) disable iff (!i_rst_n)
      (i_m_bubble != lc4_pkg::BUBBLE_NONE) |-> !i_dmem_we)
      else $error("bubble in memory stage writes data memory");

   store_addr_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_dmem_we |-> !$isunknown(i_dmem_addr))
      else $error("data write with unknown address");

   // both younger slots squashed, then they move down together
   flush_two_bubbles: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_flush |=> (i_d_bubble == lc4_pkg::BUBBLE_MISPRED
                   && i_x_bubble == lc4_pkg::BUBBLE_MISPRED)
                  ##1 (i_x_bubble == lc4_pkg::BUBBLE_MISPRED
                       && i_m_bubble == lc4_pkg::BUBBLE_MISPRED))
      else $error("taken branch did not produce two mispredict bubbles");

   pc_after_reset: assert property (@(posedge gwe)
      $rose(i_rst_n) |-> (i_pc == lc4_pkg::RESET_PC))
      else $error("pc is not the reset pc after reset");

endmodule

/* tb_lc4_processor.sv */
`timescale 1ns/1ps

module tb_lc4_processor;

   localparam int TIMEOUT_CYCLES = 500;

   logic               gwe;
   logic               i_rst_n;
   lc4_pkg::word_t     imem_addr;
   lc4_pkg::word_t     imem_insn;
   lc4_pkg::word_t     dmem_addr;
   lc4_pkg::word_t     dmem_rdata;
   lc4_pkg::word_t     dmem_wdata;
   logic               dmem_we;
   lc4_pkg::wb_trace_t wb;

   lc4_pkg::word_t imem [65536];
   lc4_pkg::word_t dmem [65536];
   lc4_pkg::word_t tdata [256];  // raw words of the data file

   int errors;
   int checks;
   int tests;
   int ptr;
   int ret_base;
   int n_ret;
   int st_base;
   int n_st;
   int retired;
   int stored;
   int cycles;
   int n_mis;
   int n_lu;
   int err_mark;

   lc4_processor i_lc4_processor (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_insn  (imem_insn),
      .o_dmem_addr  (dmem_addr),
      .i_dmem_rdata (dmem_rdata),
      .o_dmem_we    (dmem_we),
      .o_dmem_wdata (dmem_wdata),
      .o_wb         (wb)
   );

   bind lc4_processor lc4_processor_props i_lc4_processor_props (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_wb        (o_wb),
      .i_dmem_we   (o_dmem_we),
      .i_dmem_addr (o_dmem_addr),
      .i_pc        (pc_q),
      .i_flush     (flush),
      .i_d_bubble  (d_q.bubble),
      .i_x_bubble  (x_q.bubble),
      .i_m_bubble  (m_q.bubble)
   );

   // combinational memories, writes land on the rising edge
   assign imem_insn  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_addr];

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr] <= dmem_wdata;
      end
   end

   initial begin
      gwe = 1'b0;
      forever #5 gwe = ~gwe;
   end

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   // record layout: pc rf_we rd data nzp
   task automatic check_retire(input int n);
      int base;
      string tag;
      base = ret_base + 5 * n;
      tag  = $sformatf("retire %0d", n);
      check_value({tag, " pc"}, tdata[base], wb.pc);
      check_value({tag, " insn"}, imem[tdata[base]], wb.insn);  // program word at that pc
      check_value({tag, " rf_we"}, tdata[base + 1], {15'd0, wb.rf_we});
      check_value({tag, " nzp_we"}, tdata[base + 1], {15'd0, wb.nzp_we});
      if (tdata[base + 1][0]) begin  // value fields only mean something on a write
         check_value({tag, " rd"}, tdata[base + 2], {13'd0, wb.rd});
         check_value({tag, " data"}, tdata[base + 3], wb.rf_data);
         check_value({tag, " nzp"}, tdata[base + 4], {13'd0, wb.nzp});
      end
   endtask

   initial begin
      i_rst_n = 1'b0;
      errors  = 0;
      checks  = 0;
      tests   = 0;
      n_mis   = 0;
      n_lu    = 0;
      $readmemh("lc4_testdata.txt", tdata);
      for (int a = 0; a < 65536; a++) begin
         imem[a] = a[15:0] ^ 16'hc0de;
         dmem[a] = a[15:0] ^ 16'h3c5a;
      end
      for (int i = 0; i < tdata[0]; i++) begin
         imem[lc4_pkg::RESET_PC + i] = tdata[1 + i];
      end
      ptr = 1 + tdata[0];
      for (int i = 0; i < tdata[ptr]; i++) begin
         dmem[tdata[ptr + 1 + 2 * i]] = tdata[ptr + 2 + 2 * i];
      end
      ptr      = ptr + 1 + 2 * tdata[ptr];
      n_ret    = tdata[ptr];
      ret_base = ptr + 1;
      ptr      = ret_base + 5 * n_ret;
      n_st     = tdata[ptr];
      st_base  = ptr + 1;
      ptr      = st_base + 2 * n_st;  // now at the bubble counts

      repeat (5) @(negedge gwe);
      i_rst_n = 1'b1;

      // trace and store checker, sampled on the falling edge
      tests++;
      err_mark = errors;
      retired  = 0;
      stored   = 0;
      cycles   = 0;
      while (retired < n_ret && cycles < TIMEOUT_CYCLES) begin
         if (wb.bubble == lc4_pkg::BUBBLE_NONE) begin
            check_retire(retired);
            retired++;
         end else if (wb.bubble == lc4_pkg::BUBBLE_MISPRED) begin
            n_mis++;
         end else if (wb.bubble == lc4_pkg::BUBBLE_LOAD_USE) begin
            n_lu++;
         end else begin
            errors++;
            $display("unknown bubble code %0d in the retire trace", wb.bubble);
         end
         if (dmem_we) begin
            if (stored < n_st) begin
               check_value($sformatf("store %0d addr", stored),
                           tdata[st_base + 2 * stored], dmem_addr);
               check_value($sformatf("store %0d data", stored),
                           tdata[st_base + 2 * stored + 1], dmem_wdata);
            end else begin
               errors++;
               $display("data memory written more often than expected");
            end
            stored++;
         end
         @(negedge gwe);
         cycles++;
      end
      if (retired < n_ret) begin
         errors++;
         $display("timeout: only %0d of %0d instructions retired", retired, n_ret);
      end
      $display("test retire_trace: %0d instructions, %0d errors", retired, errors - err_mark);

      tests++;
      err_mark = errors;
      check_value("store count", n_st[15:0], stored[15:0]);
      $display("test store_sequence: %0d stores, %0d errors", stored, errors - err_mark);

      tests++;
      err_mark = errors;
      check_value("mispredict bubbles", tdata[ptr], n_mis[15:0]);
      check_value("load-use bubbles", tdata[ptr + 1], n_lu[15:0]);
      $display("test bubble_counts: %0d errors", errors - err_mark);

      $display("tests %0d, checks %0d, errors %0d, mispredict %0d, load-use %0d",
               tests, checks, errors, n_mis, n_lu);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* lc4_testdata.txt */
// program: word count, then instructions from 8200
0017
9010 9205 95FD 1642  // const r0 r1 r2, add r3
58C1 1B3F 1CC3 6200  // and r4, add r5 r6, ldr r1
1461 6601 0801 9E01  // add r2, ldr r3, br n, skipped const
1842 7802 6A00 7A03  // add r4, str r4, ldr r5, str r5
0801 0000 9DFF 0801  // br n not taken, nop, const r6, br n taken
9E02 1F86 0FFF       // skipped const, add r7, self loop
// data init: pair count, then address data
0002
0010 0007
0011 8000
// retirements: count, then pc rf_we rd data nzp
0015
8200 1 0 0010 1  8201 1 1 0005 1  8202 1 2 FFFD 4
8203 1 3 0002 1  8204 1 4 0000 2  8205 1 5 FFFF 4
8206 1 6 0004 1  8207 1 1 0007 1  8208 1 2 0008 1
8209 1 3 8000 4  820A 0 0 0000 0  820C 1 4 000F 1
820D 0 0 0000 0  820E 1 5 0007 1  820F 0 0 0000 0
8210 0 0 0000 0  8211 0 0 0000 0  8212 1 6 FFFF 4
8213 0 0 0000 0  8215 1 7 FFFE 4  8216 0 0 0000 0
// stores: count, then address data
0002
0012 000F
0013 0007
// bubble counts: mispredict load-use
0008 0002

/* list.f */
lc4_pkg.sv
lc4_decoder.sv
lc4_alu.sv
lc4_regfile.sv
lc4_hazard_unit.sv
lc4_processor.sv
lc4_processor_props.sv
tb_lc4_processor.sv

/* Bender.yml */
package:
  name: lc4_pipeline

sources:
  - lc4_pkg.sv
  - lc4_decoder.sv
  - lc4_alu.sv
  - lc4_regfile.sv
  - lc4_hazard_unit.sv
  - lc4_processor.sv
  - target: simulation
    files:
      - lc4_processor_props.sv
      - tb_lc4_processor.sv
